//--- verilog.f
+incdir+hw
hw/otp_lci_pkg.sv
hw/otp_lci.sv
hw/otp_prog_mem.sv
hw/otp_lci_status.sv
hw/otp_lci_top.sv
testbench/tb_clk_gen.sv
testbench/otp_lci_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal -f verilog.f --top-module otp_lci_tb \
       -Mdir obj_dir -o otp_lci_sim \
  && ./obj_dir/otp_lci_sim | tee /dev/stderr | grep -q "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation did not pass"; exit 1; }

//--- testbench/otp_lci_tb.sv
// Testbench for the OTP life-cycle path with LFSR stimulus, array model and checker
`timescale 1ns/1ps
`include "otp_lci_defs.svh"

module otp_lci_tb;

  import otp_lci_pkg::*;

  localparam logic [31:0] Seed = 32'h3860b189;
  localparam int AckLimit  = 60;
  localparam int IdleLimit = 20;
  localparam int AddrW     = `OTP_ADDR_W;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   lci_en_i;
  logic                   escalate_i;
  logic                   lc_req_i;
  logic [`LC_WIDTH-1:0]   lc_data_i;
  logic                   lc_ack_o;
  logic                   lc_err_o;
  logic                   idle_o;
  lci_status_t            status;
  logic                   fsm_err_o;
  logic                   rd_req_i;
  logic [`OTP_ADDR_W-1:0] rd_addr_i;
  logic                   rd_valid_o;
  logic [`OTP_WIDTH-1:0]  rd_data_o;

  // Reference copy of the array and the status we expect
  logic [`OTP_WIDTH-1:0] model_mem [`OTP_DEPTH];
  otp_err_e              exp_err;
  logic                  exp_locked;
  int                    exp_done;
  int                    exp_fail;

  logic [31:0] lfsr;
  int          errors;
  int          checks;

  tb_clk_gen #(.PeriodNs(40)) u_clk (.clk_o(clk_i));

  otp_lci_top uut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .lci_en_i   (lci_en_i),
    .escalate_i (escalate_i),
    .lc_req_i   (lc_req_i),
    .lc_data_i  (lc_data_i),
    .lc_ack_o   (lc_ack_o),
    .lc_err_o   (lc_err_o),
    .idle_o     (idle_o),
    .status_o   (status),
    .fsm_err_o  (fsm_err_o),
    .rd_req_i   (rd_req_i),
    .rd_addr_i  (rd_addr_i),
    .rd_valid_o (rd_valid_o),
    .rd_data_o  (rd_data_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL @ %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
    end
  endtask

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!idle_o && n < IdleLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (!idle_o) begin
      errors++;
      $display("Timeout: controller did not go idle within %0d cycles", IdleLimit);
    end
  endtask

  task automatic wait_ack(output bit acked, output logic err);
    int n;
    acked = 1'b0;
    err   = 1'b0;
    n     = 0;
    while (!acked && n < AckLimit) begin
      @(negedge clk_i);
      if (lc_ack_o) begin
        acked = 1'b1;
        err   = lc_err_o;
      end
      n++;
    end
  endtask

  // Strobe, then data valid in exactly the following cycle
  task automatic read_word(input logic [`OTP_ADDR_W-1:0] addr,
                           output logic [`OTP_WIDTH-1:0] data);
    step();
    rd_req_i  = 1'b1;
    rd_addr_i = addr;
    @(negedge clk_i);
    check(rd_valid_o, 0, "rd_valid_o before the sampling edge");
    step();
    rd_req_i = 1'b0;
    @(negedge clk_i);
    check(rd_valid_o, 1, "rd_valid_o one cycle after the strobe");
    data = rd_data_o;
    step();
    @(negedge clk_i);
    check(rd_valid_o, 0, "rd_valid_o lasts one cycle");
  endtask

  task automatic run_transition(input logic [`LC_WIDTH-1:0] value,
                                output bit acked, output logic err);
    step();
    lc_req_i  = 1'b1;
    lc_data_i = value;
    step();
    lc_req_i = 1'b0;
    wait_ack(acked, err);
  endtask

  // Write-once rule applied word by word
  task automatic apply_model(input logic [`LC_WIDTH-1:0] value, output logic err);
    logic [`OTP_WIDTH-1:0] old_w;
    logic [`OTP_WIDTH-1:0] new_w;
    err = 1'b0;
    for (int i = 0; i < `LC_WORDS; i++) begin
      old_w = model_mem[`LC_OFFSET + i];
      new_w = value[i*`OTP_WIDTH +: `OTP_WIDTH];
      if ((old_w & ~new_w) != '0) begin
        err = 1'b1;
      end else begin
        model_mem[`LC_OFFSET + i] = new_w;
      end
    end
    if (err) begin
      exp_fail++;
      exp_locked = 1'b1;
      if (exp_err == NoError) begin
        exp_err = MacroWriteBlankError;
      end
    end else begin
      exp_done++;
    end
  endtask

  task automatic check_status(input string tag);
    check(32'(status.err), 32'(exp_err), {tag, ": status error code"});
    check(status.locked, exp_locked, {tag, ": status locked"});
    check(status.done_cnt, exp_done, {tag, ": completed count"});
    check(status.fail_cnt, exp_fail, {tag, ": failed count"});
  endtask

  task automatic readback_partition(input string tag);
    logic [`OTP_WIDTH-1:0] word;
    for (int i = 0; i < `LC_WORDS; i++) begin
      read_word(AddrW'(`LC_OFFSET + i), word);
      check(word, model_mem[`LC_OFFSET + i], {tag, ": read-back word"});
    end
  endtask

  task automatic do_transition(input logic [`LC_WIDTH-1:0] value, input string tag);
    bit   acked;
    logic err;
    logic exp_lc_err;
    apply_model(value, exp_lc_err);
    run_transition(value, acked, err);
    if (!acked) begin
      errors++;
      $display("Timeout: %s got no acknowledge within %0d cycles", tag, AckLimit);
    end else begin
      check(err, exp_lc_err, {tag, ": lc_err_o"});
    end
    // Counters and lock settle after the acknowledge
    step();
    step();
    @(negedge clk_i);
    check_status(tag);
    readback_partition(tag);
  endtask

  task automatic apply_reset();
    rst_ni     = 1'b0;
    lci_en_i   = 1'b0;
    escalate_i = 1'b0;
    lc_req_i   = 1'b0;
    rd_req_i   = 1'b0;
    for (int i = 0; i < `OTP_DEPTH; i++) begin
      model_mem[i] = '0;
    end
    exp_err    = NoError;
    exp_locked = 1'b0;
    exp_done   = 0;
    exp_fail   = 0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [`LC_WIDTH-1:0]  value;
    logic [`OTP_WIDTH-1:0] old_w;
    logic [`OTP_WIDTH-1:0] new_w;
    logic [`OTP_WIDTH-1:0] word;
    logic [31:0]           r;
    logic [31:0]           pick;
    bit                    acked;
    logic                  err;

    rst_ni     = 1'b0;
    lci_en_i   = 1'b0;
    escalate_i = 1'b0;
    lc_req_i   = 1'b0;
    lc_data_i  = '0;
    rd_req_i   = 1'b0;
    rd_addr_i  = '0;
    lfsr       = Seed;
    errors     = 0;
    checks     = 0;

    // Reset state and enable
    apply_reset();
    @(negedge clk_i);
    check(idle_o, 0, "idle_o low before enable");
    check_status("after reset");
    rand_bits(`OTP_ADDR_W, r);
    read_word(r[`OTP_ADDR_W-1:0], word);
    check(word, 0, "blank array read");
    step();
    lci_en_i = 1'b1;
    wait_idle();

    // Blank words, every word gets at least one bit
    for (int i = 0; i < `LC_WORDS; i++) begin
      rand_bits(`OTP_WIDTH, r);
      value[i*`OTP_WIDTH +: `OTP_WIDTH] = r[`OTP_WIDTH-1:0] | (`OTP_WIDTH'(1) << i);
    end
    do_transition(value, "blank transition");

    // Superset of the stored bits, the array word must fit inside it
    for (int i = 0; i < `LC_WORDS; i++) begin
      rand_bits(`OTP_WIDTH, r);
      old_w = model_mem[`LC_OFFSET + i];
      new_w = old_w | r[`OTP_WIDTH-1:0];
      read_word(AddrW'(`LC_OFFSET + i), word);
      check(word & ~new_w, 0, "stored word is a subset of the new value");
      value[i*`OTP_WIDTH +: `OTP_WIDTH] = new_w;
    end
    do_transition(value, "superset transition");

    // Word 0 and a random choice of others drop their lowest stored bit
    for (int i = 0; i < `LC_WORDS; i++) begin
      rand_bits(1, pick);
      rand_bits(`OTP_WIDTH, r);
      old_w = model_mem[`LC_OFFSET + i];
      new_w = old_w | r[`OTP_WIDTH-1:0];
      if (i == 0 || pick[0]) begin
        new_w = new_w & ~(old_w & (~old_w + 1'b1));
      end
      value[i*`OTP_WIDTH +: `OTP_WIDTH] = new_w;
    end
    do_transition(value, "clearing transition");
    run_transition(value, acked, err);
    check(acked, 0, "request in the error state is not acknowledged");

    // Random read-back over the whole array
    repeat (6) begin
      rand_bits(`OTP_ADDR_W, r);
      read_word(r[`OTP_ADDR_W-1:0], word);
      check(word, model_mem[r[`OTP_ADDR_W-1:0]], "random address read");
    end

    // Escalation after a fresh reset
    step();
    apply_reset();
    @(negedge clk_i);
    check_status("second reset");
    step();
    lci_en_i = 1'b1;
    wait_idle();
    step();
    escalate_i = 1'b1;
    @(negedge clk_i);
    check(fsm_err_o, 1, "escalation raises fsm_err_o");
    step();
    escalate_i = 1'b0;
    @(negedge clk_i);
    check(fsm_err_o, 0, "fsm_err_o is a single pulse");
    step();
    @(negedge clk_i);
    exp_err    = FsmStateError;
    exp_locked = 1'b1;
    check_status("after escalation");
    run_transition(value, acked, err);
    check(acked, 0, "request after escalation is not acknowledged");

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clk_gen.sv
// Free-running clock source for the testbench
`timescale 1ns/1ps

module tb_clk_gen #(
  // Full clock period in ns
  parameter int PeriodNs = 40
) (
  output logic clk_o
);

  // Low at time zero, first rising edge after half a period
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(PeriodNs / 2);
    clk_o = ~clk_o;
  end

endmodule

//--- hw/otp_lci_top.sv
// Top level of the life-cycle programming path with controller, array and status
`timescale 1ns/1ps
`include "otp_lci_defs.svh"

module otp_lci_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      lci_en_i,
  input  logic                      escalate_i,
  // Life-cycle request strobe and value
  input  logic                      lc_req_i,
  input  logic [`LC_WIDTH-1:0]      lc_data_i,
  output logic                      lc_ack_o,
  output logic                      lc_err_o,
  output logic                      idle_o,
  output otp_lci_pkg::lci_status_t  status_o,
  output logic                      fsm_err_o,
  // Array read-back
  input  logic                      rd_req_i,
  input  logic [`OTP_ADDR_W-1:0]    rd_addr_i,
  output logic                      rd_valid_o,
  output logic [`OTP_WIDTH-1:0]     rd_data_o
);

  import otp_lci_pkg::*;

  // Controller to array
  logic     otp_req;
  otp_req_t otp_cmd;
  logic     otp_gnt;
  logic     otp_rvalid;
  otp_rsp_t otp_rsp;

  // Controller to status block
  logic     done;
  logic     fail;
  otp_err_e err_code;
  logic     err_we;
  logic     lock;

  //////////////////////////////////////////////////////////////////////////////
  // Request capture and word sequencing
  //////////////////////////////////////////////////////////////////////////////

  otp_lci u_lci (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lci_en_i     (lci_en_i),
    .escalate_i   (escalate_i),
    .lc_req_i     (lc_req_i),
    .lc_data_i    (lc_data_i),
    .lc_ack_o     (lc_ack_o),
    .lc_err_o     (lc_err_o),
    .idle_o       (idle_o),
    .fsm_err_o    (fsm_err_o),
    .otp_req_o    (otp_req),
    .otp_cmd_o    (otp_cmd),
    .otp_gnt_i    (otp_gnt),
    .otp_rvalid_i (otp_rvalid),
    .otp_rsp_i    (otp_rsp),
    .done_o       (done),
    .fail_o       (fail),
    .err_code_o   (err_code),
    .err_we_o     (err_we),
    .lock_o       (lock)
  );

  // OTP array
  otp_prog_mem u_mem (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (otp_req),
    .cmd_i      (otp_cmd),
    .gnt_o      (otp_gnt),
    .rvalid_o   (otp_rvalid),
    .rsp_o      (otp_rsp),
    .rd_req_i   (rd_req_i),
    .rd_addr_i  (rd_addr_i),
    .rd_valid_o (rd_valid_o),
    .rd_data_o  (rd_data_o)
  );

  // Result stage
  otp_lci_status u_status (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .done_i     (done),
    .fail_i     (fail),
    .err_code_i (err_code),
    .err_we_i   (err_we),
    .lock_i     (lock),
    .status_o   (status_o)
  );

endmodule

//--- hw/otp_lci_status.sv
// Result stage with sticky error code, lock flag and transition counters
`timescale 1ns/1ps

module otp_lci_status (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Transition end and its outcome
  input  logic                      done_i,
  input  logic                      fail_i,
  // Error code load request
  input  otp_lci_pkg::otp_err_e     err_code_i,
  input  logic                      err_we_i,
  // Controller sits in its terminal state
  input  logic                      lock_i,
  output otp_lci_pkg::lci_status_t  status_o
);

  import otp_lci_pkg::*;

  lci_status_t status_q;

  //////////////////////////////////////////////////////////////////////////////
  // Status register
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q.err      <= NoError;
      status_q.locked   <= 1'b0;
      status_q.done_cnt <= '0;
      status_q.fail_cnt <= '0;
    end else begin
      // First real error code sticks until reset
      if (err_we_i && err_code_i != NoError && status_q.err == NoError) begin
        status_q.err <= err_code_i;
      end

      if (lock_i) begin
        status_q.locked <= 1'b1;
      end

      // Saturating counters
      if (done_i && !fail_i && status_q.done_cnt != 8'hff) begin
        status_q.done_cnt <= status_q.done_cnt + 8'd1;
      end
      if (done_i && fail_i && status_q.fail_cnt != 8'hff) begin
        status_q.fail_cnt <= status_q.fail_cnt + 8'd1;
      end
    end
  end

  assign status_o = status_q;

endmodule

//--- hw/otp_prog_mem.sv
// Behavioral write-once OTP array with granted write port and strobed read port
`timescale 1ns/1ps
`include "otp_lci_defs.svh"

module otp_prog_mem (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Write port with request, grant and response
  input  logic                      req_i,
  input  otp_lci_pkg::otp_req_t     cmd_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output otp_lci_pkg::otp_rsp_t     rsp_o,
  // Read port
  input  logic                      rd_req_i,
  input  logic [`OTP_ADDR_W-1:0]    rd_addr_i,
  output logic                      rd_valid_o,
  output logic [`OTP_WIDTH-1:0]     rd_data_o
);

  import otp_lci_pkg::*;

  // Array storage, all bits blank at reset
  logic [`OTP_WIDTH-1:0] mem_q [`OTP_DEPTH];

  logic                  wr_en;
  logic                  blank_err;
  logic [`OTP_WIDTH-1:0] cur_word;
  otp_rsp_t              rsp_d;
  otp_rsp_t              rsp_q;
  logic                  rvalid_q;
  logic                  rd_valid_q;
  logic [`OTP_WIDTH-1:0] rd_data_q;

  //////////////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////////////

  // Array never stalls
  assign gnt_o = req_i;

  assign cur_word = mem_q[cmd_i.addr];

  // A stored one that the new word would clear
  assign blank_err = |(cur_word & ~cmd_i.data);

  always_comb begin
    wr_en       = 1'b0;
    rsp_d.err   = NoError;
    if (req_i && gnt_o && cmd_i.cmd == Write) begin
      if (blank_err) begin
        rsp_d.err = MacroWriteBlankError;
      end else begin
        wr_en = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `OTP_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rvalid_q   <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        mem_q[cmd_i.addr] <= cmd_i.data;
      end
      // Response one cycle after the grant
      rvalid_q   <= req_i & gnt_o;
      rd_valid_q <= rd_req_i;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Response and read data
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rsp_q <= rsp_d;
    end
    // Read returns the word as stored before any same-cycle write
    if (rd_req_i) begin
      rd_data_q <= mem_q[rd_addr_i];
    end
  end

  assign rvalid_o   = rvalid_q;
  assign rsp_o      = rsp_q;
  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = rd_data_q;

endmodule

//--- hw/otp_lci.sv
// Life-cycle interface FSM that captures a transition request and burns it into OTP
`timescale 1ns/1ps
`include "otp_lci_defs.svh"

module otp_lci (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      lci_en_i,
  input  logic                      escalate_i,
  // Life-cycle transition request
  input  logic                      lc_req_i,
  input  logic [`LC_WIDTH-1:0]      lc_data_i,
  output logic                      lc_ack_o,
  output logic                      lc_err_o,
  output logic                      idle_o,
  output logic                      fsm_err_o,
  // Write path to the OTP array
  output logic                      otp_req_o,
  output otp_lci_pkg::otp_req_t     otp_cmd_o,
  input  logic                      otp_gnt_i,
  input  logic                      otp_rvalid_i,
  input  otp_lci_pkg::otp_rsp_t     otp_rsp_i,
  // Result reporting
  output logic                      done_o,
  output logic                      fail_o,
  output otp_lci_pkg::otp_err_e     err_code_o,
  output logic                      err_we_o,
  output logic                      lock_o
);

  import otp_lci_pkg::*;

  localparam int CntW  = $clog2(`LC_WORDS);
  localparam int AddrW = `OTP_ADDR_W;
  localparam logic [CntW-1:0] LastWord = CntW'(`LC_WORDS - 1);

  typedef enum logic [2:0] {
    ResetSt,
    IdleSt,
    WriteSt,
    WriteWaitSt,
    ErrorSt
  } state_e;

  state_e state_d, state_q;

  // Word counter within one transition
  logic [CntW-1:0] cnt_d, cnt_q;

  // Error seen so far in this transition
  otp_err_e err_d, err_q;

  // Captured request value, one entry per native word
  logic [`LC_WORDS-1:0][`OTP_WIDTH-1:0] lc_data_q;
  logic                                 accept;

  //////////////////////////////////////////////////////////////////////////////
  // Controller FSM
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    err_d      = err_q;
    accept     = 1'b0;
    idle_o     = 1'b1;
    otp_req_o  = 1'b0;
    lc_ack_o   = 1'b0;
    lc_err_o   = 1'b0;
    fsm_err_o  = 1'b0;
    err_code_o = NoError;
    err_we_o   = 1'b0;

    unique case (state_q)
      // Hold here until the interface is enabled
      ResetSt: begin
        idle_o = 1'b0;
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      // Only here is a request strobe honored
      IdleSt: begin
        if (lc_req_i) begin
          accept  = 1'b1;
          state_d = WriteSt;
          cnt_d   = '0;
          err_d   = NoError;
        end
      end
      // Present the current word until the array grants it
      WriteSt: begin
        idle_o    = 1'b0;
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = WriteWaitSt;
        end
      end
      // Collect the response, then move on or finish
      WriteWaitSt: begin
        idle_o = 1'b0;
        if (otp_rvalid_i) begin
          // Keep the failure but still try the remaining words
          if (otp_rsp_i.err != NoError) begin
            err_d      = otp_rsp_i.err;
            err_code_o = otp_rsp_i.err;
            err_we_o   = 1'b1;
          end
          if (cnt_q == LastWord) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            // Any refused word locks the partition
            if (err_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_d   = cnt_q + 1'b1;
            state_d = WriteSt;
          end
        end
      end
      // Terminal state, left only by reset
      ErrorSt: begin
        err_code_o = FsmStateError;
        err_we_o   = 1'b1;
      end
      // Unreachable encodings
      default: begin
        state_d    = ErrorSt;
        fsm_err_o  = 1'b1;
        err_code_o = FsmStateError;
        err_we_o   = 1'b1;
      end
    endcase

    // Escalation wins over everything else
    if (escalate_i && state_q != ErrorSt) begin
      state_d    = ErrorSt;
      fsm_err_o  = 1'b1;
      err_code_o = FsmStateError;
      err_we_o   = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Word and address selection
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    otp_cmd_o.cmd  = otp_req_o ? Write : Read;
    otp_cmd_o.addr = AddrW'(`LC_OFFSET) + AddrW'(cnt_q);
    // Data bus stays quiet outside write requests
    otp_cmd_o.data = otp_req_o ? lc_data_q[cnt_q] : '0;
  end

  // Status block sees the acknowledge and the terminal state
  assign done_o = lc_ack_o;
  assign fail_o = lc_err_o;
  assign lock_o = (state_q == ErrorSt);

  //////////////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      cnt_q   <= '0;
      err_q   <= NoError;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      err_q   <= err_d;
    end
  end

  // Request value captured on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      lc_data_q <= lc_data_i;
    end
  end

endmodule

//--- hw/otp_lci_pkg.sv
// Error codes, command encoding and request, response and status structs
`include "otp_lci_defs.svh"

package otp_lci_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////////////

  // Partition error code, NoError must stay zero
  typedef enum logic [1:0] {
    NoError              = 2'd0,
    MacroWriteBlankError = 2'd1,
    FsmStateError        = 2'd2
  } otp_err_e;

  // Command on the controller to array path
  typedef enum logic [0:0] {
    Read  = 1'b0,
    Write = 1'b1
  } otp_cmd_e;

  //////////////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////////////

  // One native word transfer towards the array
  typedef struct packed {
    otp_cmd_e                 cmd;
    logic [`OTP_ADDR_W-1:0]   addr;
    logic [`OTP_WIDTH-1:0]    data;
  } otp_req_t;

  // Array answer, qualified by rvalid
  typedef struct packed {
    otp_err_e err;
  } otp_rsp_t;

  // Partition status seen from outside
  typedef struct packed {
    otp_err_e   err;
    logic       locked;
    // Transitions that ended without error
    logic [7:0] done_cnt;
    // Transitions that ended with error
    logic [7:0] fail_cnt;
  } lci_status_t;

endpackage

//--- hw/otp_lci_defs.svh
// Widths, word counts, array depth and partition offset of the OTP life-cycle path
`ifndef OTP_LCI_DEFS_SVH
`define OTP_LCI_DEFS_SVH

//////////////////////////////////////////////////////////////////////////////
// Native OTP geometry
//////////////////////////////////////////////////////////////////////////////

// Native OTP word width in bits
`define OTP_WIDTH 16

// Number of words in the behavioral array
`define OTP_DEPTH 32

// Word address width derived from the depth
`define OTP_ADDR_W $clog2(`OTP_DEPTH)

//////////////////////////////////////////////////////////////////////////////
// Life-cycle partition
//////////////////////////////////////////////////////////////////////////////

// Native words per life-cycle value
`define LC_WORDS 8

// Full life-cycle value width, 128 bits
`define LC_WIDTH (`OTP_WIDTH * `LC_WORDS)

// Word address of the first life-cycle word
`define LC_OFFSET 16

`endif
